/* Makefile */
# Verilator build and run of the store path testbench

SIM  := obj_dir/Vstore_path_tb
SRCS := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): store_path.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -j 0 \
		--top-module store_path_tb -f store_path.f

# the run fails unless the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

/* hdl/store_buffer.sv */
/*
 * store buffer of one hart, holds stores speculatively until the core commits them
 * committed stores wait in the commit queue and are offered to the drain arbiter
 */

`include "store_path_defines.svh"
`default_nettype none

module store_buffer import store_path_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  store_lane_if.lane   core_i,
  store_drain_if.lane  drain_o
);

  // speculative queue, stores the core may still throw away
  store_entry_t spec_q [`SP_DEPTH_SPEC];
  store_entry_t spec_n [`SP_DEPTH_SPEC];
  spec_ptr_t    spec_rd_q;
  spec_ptr_t    spec_rd_n;
  spec_ptr_t    spec_wr_q;
  spec_ptr_t    spec_wr_n;
  spec_cnt_t    spec_cnt_q;
  spec_cnt_t    spec_cnt_n;

  // commit queue, stores that will reach memory for sure
  store_entry_t cmt_q [`SP_DEPTH_COMMIT];
  store_entry_t cmt_n [`SP_DEPTH_COMMIT];
  commit_ptr_t  cmt_rd_q;
  commit_ptr_t  cmt_rd_n;
  commit_ptr_t  cmt_wr_q;
  commit_ptr_t  cmt_wr_n;
  commit_cnt_t  cmt_cnt_q;
  commit_cnt_t  cmt_cnt_n;

  logic         push_ok;

  // a full queue can still take a push when the commit frees its head this cycle
  assign core_i.ready        = (spec_cnt_q < `SP_DEPTH_SPEC) || core_i.commit;
  assign core_i.commit_ready = cmt_cnt_q < `SP_DEPTH_COMMIT;
  assign core_i.empty        = (spec_cnt_q == '0) && (cmt_cnt_q == '0);

  assign push_ok = core_i.push && core_i.ready;

  // ------------------------------
  // speculative queue
  // ------------------------------
  always_comb begin : spec_next
    spec_n     = spec_q;
    spec_rd_n  = spec_rd_q;
    spec_wr_n  = spec_wr_q;
    spec_cnt_n = spec_cnt_q + spec_cnt_t'(push_ok) - spec_cnt_t'(core_i.commit);

    // the head moves over to the commit queue, it is retired before the push
    // so that a push into the freed slot of a full queue stays valid
    if (core_i.commit) begin
      spec_n[spec_rd_q].valid = 1'b0;
      spec_rd_n               = spec_rd_q + 1'b1;
    end

    if (push_ok) begin
      spec_n[spec_wr_q]       = core_i.entry;
      spec_n[spec_wr_q].valid = 1'b1;
      spec_wr_n               = spec_wr_q + 1'b1;
    end

    // flush drops everything not yet committed, a push in the same cycle too
    if (core_i.flush) begin
      for (int i = 0; i < `SP_DEPTH_SPEC; i++) begin
        spec_n[i].valid = 1'b0;
      end
      spec_wr_n  = spec_rd_q;
      spec_cnt_n = '0;
    end
  end

  // ------------------------------
  // commit queue and drain side
  // ------------------------------
  assign drain_o.head = cmt_q[cmt_rd_q];
  assign drain_o.req  = cmt_q[cmt_rd_q].valid;

  always_comb begin : commit_next
    cmt_n     = cmt_q;
    cmt_rd_n  = cmt_rd_q;
    cmt_wr_n  = cmt_wr_q;
    cmt_cnt_n = cmt_cnt_q + commit_cnt_t'(core_i.commit) - commit_cnt_t'(drain_o.gnt);

    // the APB write of the head is done, retire it
    if (drain_o.gnt) begin
      cmt_n[cmt_rd_q].valid = 1'b0;
      cmt_rd_n              = cmt_rd_q + 1'b1;
    end

    // copy the speculative head into the tail, it is eligible next cycle
    if (core_i.commit) begin
      cmt_n[cmt_wr_q] = spec_q[spec_rd_q];
      cmt_wr_n        = cmt_wr_q + 1'b1;
    end
  end

  // ------------------------------
  // page offset check
  // ------------------------------
  // a load has to wait while any store of this hart may hit the same word
  // of the page, offsets are identical in virtual and physical space
  always_comb begin : offset_check
    core_i.page_match = 1'b0;
    for (int i = 0; i < `SP_DEPTH_SPEC; i++) begin
      if (spec_q[i].valid && (spec_q[i].addr[11:2] == core_i.page_offset[11:2])) begin
        core_i.page_match = 1'b1;
      end
    end
    for (int i = 0; i < `SP_DEPTH_COMMIT; i++) begin
      if (cmt_q[i].valid && (cmt_q[i].addr[11:2] == core_i.page_offset[11:2])) begin
        core_i.page_match = 1'b1;
      end
    end
    // the store arriving right now counts as well
    if (core_i.push && (core_i.entry.addr[11:2] == core_i.page_offset[11:2])) begin
      core_i.page_match = 1'b1;
    end
  end

  // state registers, entries are cleared so that no stale valid bit survives reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin : regs
    if (!arst_n_i) begin
      spec_q     <= '{default: '0};
      spec_rd_q  <= '0;
      spec_wr_q  <= '0;
      spec_cnt_q <= '0;
      cmt_q      <= '{default: '0};
      cmt_rd_q   <= '0;
      cmt_wr_q   <= '0;
      cmt_cnt_q  <= '0;
    end else begin
      spec_q     <= spec_n;
      spec_rd_q  <= spec_rd_n;
      spec_wr_q  <= spec_wr_n;
      spec_cnt_q <= spec_cnt_n;
      cmt_q      <= cmt_n;
      cmt_rd_q   <= cmt_rd_n;
      cmt_wr_q   <= cmt_wr_n;
      cmt_cnt_q  <= cmt_cnt_n;
    end
  end

endmodule

`default_nettype wire

/* hdl/store_dispatch.sv */
/*
 * steers pushes, commits and flushes from the core to the lane of the named hart
 * and returns that lane's ready flags, the load check is answered for load_hart_i
 */

`include "store_path_defines.svh"
`default_nettype none

module store_dispatch import store_path_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  hart_t       hart_i,
  input  logic        push_i,
  input  addr_t       addr_i,
  input  data_t       data_i,
  input  strb_t       strb_i,
  input  logic        commit_i,
  input  logic        flush_i,
  input  hart_t       load_hart_i,
  input  logic [11:0] page_offset_i,
  output logic        ready_o,
  output logic        commit_ready_o,
  output logic        page_offset_matches_o,
  store_lane_if.dispatch lane_o [`SP_NUM_HARTS]
);

  logic [`SP_NUM_HARTS-1:0] hit;
  logic [`SP_NUM_HARTS-1:0] ready_vec;
  logic [`SP_NUM_HARTS-1:0] commit_ready_vec;
  logic [`SP_NUM_HARTS-1:0] match_vec;
  logic                     hart_ok;
  logic                     load_hart_ok;
  logic                     bad_hart_q;
  store_entry_t             entry;

  // hart numbers beyond the configured count address no lane
  assign hart_ok      = int'(hart_i) < `SP_NUM_HARTS;
  assign load_hart_ok = int'(load_hart_i) < `SP_NUM_HARTS;

  // the same entry goes to every lane, only the addressed one sees push
  assign entry = '{addr: addr_i, data: data_i, strb: strb_i, valid: 1'b1};

  // one-hot lane select
  always_comb begin : decode
    hit = '0;
    if (hart_ok) begin
      hit[hart_i] = 1'b1;
    end
  end

  // once the core has used an invalid hart number the store path stalls it
  // until the next reset, a misrouted store cannot be recovered here
  always_ff @(posedge clk_i or negedge arst_n_i) begin : sticky_bad_hart
    if (!arst_n_i) begin
      bad_hart_q <= 1'b0;
    end else if ((push_i || commit_i || flush_i) && !hart_ok) begin
      bad_hart_q <= 1'b1;
    end
  end

  // ------------------------------
  // per lane request fan-out
  // ------------------------------
  for (genvar i = 0; i < `SP_NUM_HARTS; i++) begin : g_lane
    assign lane_o[i].push        = push_i && hit[i];
    // flush wins over commit, and a commit only goes in when the queue has room
    assign lane_o[i].commit      = commit_i && !flush_i && hit[i] && commit_ready_vec[i];
    assign lane_o[i].flush       = flush_i && hit[i];
    assign lane_o[i].entry       = entry;
    assign lane_o[i].page_offset = page_offset_i;

    assign ready_vec[i]        = lane_o[i].ready;
    assign commit_ready_vec[i] = lane_o[i].commit_ready;
    assign match_vec[i]        = lane_o[i].page_match;
  end

  // status of the addressed lane goes back to the core
  assign ready_o        = hart_ok && !bad_hart_q && ready_vec[hart_i];
  assign commit_ready_o = hart_ok && !bad_hart_q && commit_ready_vec[hart_i];

  // the load side names its own hart
  assign page_offset_matches_o = load_hart_ok && match_vec[load_hart_i];

endmodule

`default_nettype wire

/* hdl/store_drain_arbiter.sv */
/*
 * drains the commit queues of all harts through one APB requester
 * lanes are served round robin, each committed store becomes one APB write
 */

`include "store_path_defines.svh"
`default_nettype none

module store_drain_arbiter import store_path_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  store_drain_if.arbiter lanes_i [`SP_NUM_HARTS],
  output logic  psel_o,
  output logic  penable_o,
  output logic  pwrite_o,
  output addr_t paddr_o,
  output data_t pwdata_o,
  output strb_t pstrb_o,
  input  logic  pready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e               state_q;
  apb_state_e               state_n;
  hart_t                    prio_q;
  hart_t                    sel_q;
  hart_t                    pick;
  store_entry_t             entry_q;
  logic [`SP_NUM_HARTS-1:0] req_vec;
  logic [`SP_NUM_HARTS-1:0] gnt_vec;
  store_entry_t             head_vec [`SP_NUM_HARTS];
  logic                     done;

  for (genvar i = 0; i < `SP_NUM_HARTS; i++) begin : g_lane
    assign req_vec[i]     = lanes_i[i].req;
    assign head_vec[i]    = lanes_i[i].head;
    assign lanes_i[i].gnt = gnt_vec[i];
  end

  // first requesting lane at or after the priority pointer
  always_comb begin : rr_pick
    int   idx;
    logic found;
    pick  = prio_q;
    found = 1'b0;
    for (int k = 0; k < `SP_NUM_HARTS; k++) begin
      idx = (int'(prio_q) + k) % `SP_NUM_HARTS;
      if (!found && req_vec[idx]) begin
        pick  = hart_t'(idx);
        found = 1'b1;
      end
    end
  end

  // ------------------------------
  // APB requester
  // ------------------------------
  // transfer ends when the completer signals ready in the access phase
  assign done = (state_q == ST_ACCESS) && pready_i;

  always_comb begin : fsm_next
    state_n = state_q;
    case (state_q)
      ST_IDLE:   if (|req_vec) state_n = ST_SETUP;
      ST_SETUP:  state_n = ST_ACCESS;
      ST_ACCESS: if (pready_i) state_n = ST_IDLE;
      default:   state_n = ST_IDLE;
    endcase
  end

  // the granted lane pops its head at the completing edge
  always_comb begin : grant
    gnt_vec = '0;
    if (done) begin
      gnt_vec[sel_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : fsm_regs
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      prio_q  <= '0;
      sel_q   <= '0;
    end else begin
      state_q <= state_n;
      if (state_q == ST_IDLE && (|req_vec)) begin
        sel_q <= pick;
      end
      // the lane just served drops to lowest priority
      if (done) begin
        prio_q <= (int'(sel_q) == `SP_NUM_HARTS - 1) ? '0 : sel_q + 1'b1;
      end
    end
  end

  // captured when setup begins, held stable through any wait states
  always_ff @(posedge clk_i) begin : entry_latch
    if (state_q == ST_IDLE && (|req_vec)) begin
      entry_q <= head_vec[pick];
    end
  end

  assign psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign penable_o = state_q == ST_ACCESS;
  // this port only ever writes
  assign pwrite_o  = 1'b1;
  assign paddr_o   = entry_q.addr;
  assign pwdata_o  = entry_q.data;
  assign pstrb_o   = entry_q.strb;

endmodule

`default_nettype wire

/* hdl/store_drain_if.sv */
/*
 * link between one store buffer and the drain arbiter
 * the lane offers its oldest committed store, the arbiter grants on APB completion
 */

`default_nettype none

interface store_drain_if import store_path_pkg::*; ();

  // head of the commit queue is waiting to be written
  logic         req;
  store_entry_t head;
  // one cycle pulse when the APB write of the head has completed
  logic         gnt;

  modport lane (
    output req, head,
    input  gnt
  );

  modport arbiter (
    input  req, head,
    output gnt
  );

endinterface

`default_nettype wire

/* hdl/store_lane_if.sv */
/*
 * link between the dispatcher and one store buffer
 * the dispatcher steers core requests in, the lane reports its status back
 */

`default_nettype none

interface store_lane_if import store_path_pkg::*; ();

  // requests from the dispatcher, at most one of commit and flush is high
  logic         push;
  logic         commit;
  logic         flush;
  store_entry_t entry;
  // page offset of the load being checked against this lane
  logic [11:0]  page_offset;

  // status from the lane
  logic         ready;
  logic         commit_ready;
  logic         page_match;
  // nothing speculative and nothing waiting to drain
  logic         empty;

  // empty is read straight off the interface by the top level
  modport dispatch (
    output push, commit, flush, entry, page_offset,
    input  ready, commit_ready, page_match
  );

  modport lane (
    input  push, commit, flush, entry, page_offset,
    output ready, commit_ready, page_match, empty
  );

endinterface

`default_nettype wire

/* hdl/store_path_defines.svh */
/*
 * sizing macros for the multi-hart store path
 * included by the package and by every module that needs a depth or width
 * change the values here to resize all store buffers and the APB port together
 */

`ifndef STORE_PATH_DEFINES_SVH
`define STORE_PATH_DEFINES_SVH

// number of harts, one store buffer each, must be at least 2
`define SP_NUM_HARTS 2

// queue depths, both must be powers of two so the pointers wrap on their own
`define SP_DEPTH_SPEC 4
`define SP_DEPTH_COMMIT 4

// physical address and store data widths, the address needs at least 12 bits
// because the load check looks at the page offset
`define SP_ADDR_W 16
`define SP_DATA_W 32

`endif

/* hdl/store_path_pkg.sv */
/*
 * common types of the store path
 * every module and interface imports this package by a wildcard import
 */

`include "store_path_defines.svh"
`default_nettype none

package store_path_pkg;

  // basic words carried from the core to the APB port
  typedef logic [`SP_ADDR_W-1:0]   addr_t;
  typedef logic [`SP_DATA_W-1:0]   data_t;
  typedef logic [`SP_DATA_W/8-1:0] strb_t;

  // hart number, also used to index the lanes
  typedef logic [$clog2(`SP_NUM_HARTS)-1:0] hart_t;

  // ring buffer pointers and occupancy counters, the counters carry one extra
  // bit so that a full queue can be told apart from an empty one
  typedef logic [$clog2(`SP_DEPTH_SPEC)-1:0]   spec_ptr_t;
  typedef logic [$clog2(`SP_DEPTH_SPEC):0]     spec_cnt_t;
  typedef logic [$clog2(`SP_DEPTH_COMMIT)-1:0] commit_ptr_t;
  typedef logic [$clog2(`SP_DEPTH_COMMIT):0]   commit_cnt_t;

  // one store as it sits in either queue
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
    // marks a live entry, also used by the page offset check
    logic  valid;
  } store_entry_t;

endpackage

`default_nettype wire

/* hdl/store_path_top.sv */
/*
 * top level of the multi-hart store path
 * core requests enter by hart number, committed stores leave on one APB port
 */

`include "store_path_defines.svh"
`default_nettype none

module store_path_top import store_path_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // core side
  input  hart_t       hart_i,
  input  logic        push_i,
  input  addr_t       addr_i,
  input  data_t       data_i,
  input  strb_t       strb_i,
  input  logic        commit_i,
  input  logic        flush_i,
  output logic        ready_o,
  output logic        commit_ready_o,
  input  hart_t       load_hart_i,
  input  logic [11:0] page_offset_i,
  output logic        page_offset_matches_o,
  output logic        store_buffer_empty_o,
  // APB requester
  output logic        psel_o,
  output logic        penable_o,
  output logic        pwrite_o,
  output addr_t       paddr_o,
  output data_t       pwdata_o,
  output strb_t       pstrb_o,
  input  logic        pready_i
);

  store_lane_if  lane_bus  [`SP_NUM_HARTS] ();
  store_drain_if drain_bus [`SP_NUM_HARTS] ();

  logic [`SP_NUM_HARTS-1:0] empty_vec;

  store_dispatch store_dispatch_inst (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .hart_i                (hart_i),
    .push_i                (push_i),
    .addr_i                (addr_i),
    .data_i                (data_i),
    .strb_i                (strb_i),
    .commit_i              (commit_i),
    .flush_i               (flush_i),
    .load_hart_i           (load_hart_i),
    .page_offset_i         (page_offset_i),
    .ready_o               (ready_o),
    .commit_ready_o        (commit_ready_o),
    .page_offset_matches_o (page_offset_matches_o),
    .lane_o                (lane_bus)
  );

  // one store buffer per hart
  for (genvar i = 0; i < `SP_NUM_HARTS; i++) begin : g_hart
    store_buffer store_buffer_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .core_i   (lane_bus[i]),
      .drain_o  (drain_bus[i])
    );
    assign empty_vec[i] = lane_bus[i].empty;
  end

  store_drain_arbiter store_drain_arbiter_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .lanes_i   (drain_bus),
    .psel_o    (psel_o),
    .penable_o (penable_o),
    .pwrite_o  (pwrite_o),
    .paddr_o   (paddr_o),
    .pwdata_o  (pwdata_o),
    .pstrb_o   (pstrb_o),
    .pready_i  (pready_i)
  );

  // the whole path is empty only when every hart's buffer is
  assign store_buffer_empty_o = &empty_vec;

endmodule

`default_nettype wire

/* store_path.f */
+incdir+hdl
+incdir+verif
hdl/store_path_pkg.sv
hdl/store_lane_if.sv
hdl/store_drain_if.sv
hdl/store_dispatch.sv
hdl/store_buffer.sv
hdl/store_drain_arbiter.sv
hdl/store_path_top.sv
verif/store_path_tb.sv

/* verif/store_path_tests.svh */
/*
 * directed tests of the store path, included into the testbench module
 * every task starts and ends just after a rising edge
 */

`ifndef STORE_PATH_TESTS_SVH
`define STORE_PATH_TESTS_SVH

// ------------------------------
// core side drivers
// ------------------------------
task automatic step();
  @(posedge clk_i);
  #1;
endtask

// holds the push until the named hart reports room
task automatic push_store(input int h, input addr_t a, input data_t d, input strb_t s);
  int     n;
  write_t entry;
  n      = 0;
  hart_i = hart_t'(h);
  addr_i = a;
  data_i = d;
  strb_i = s;
  push_i = 1'b1;
  @(negedge clk_i);
  while (!ready_o && n < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    n++;
  end
  if (ready_o) begin
    entry = '{addr: a, data: d, strb: s};
    spec_model[h].push_back(entry);
  end else begin
    report_timeout("ready_o before a push");
  end
  step();
  push_i = 1'b0;
endtask

// the oldest speculative store of the hart becomes committed
task automatic commit_store(input int h);
  int n;
  n        = 0;
  hart_i   = hart_t'(h);
  commit_i = 1'b1;
  @(negedge clk_i);
  while (!commit_ready_o && n < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    n++;
  end
  if (!commit_ready_o) begin
    report_timeout("commit_ready_o before a commit");
  end else if (spec_model[h].size() > 0) begin
    cmt_model[h].push_back(spec_model[h].pop_front());
  end
  step();
  commit_i = 1'b0;
endtask

task automatic flush_hart(input int h);
  hart_i  = hart_t'(h);
  flush_i = 1'b1;
  step();
  flush_i = 1'b0;
  spec_model[h].delete();
endtask

// changed mid cycle so the completer sees it at a clean point
task automatic set_stall(input logic v);
  @(negedge clk_i);
  stall_apb = v;
  step();
endtask

task automatic wait_empty();
  int n;
  n = 0;
  @(negedge clk_i);
  while (!store_buffer_empty_o && n < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    n++;
  end
  if (!store_buffer_empty_o) begin
    report_timeout("store_buffer_empty_o");
  end
  step();
endtask

task automatic probe_match(input int lh, input logic [11:0] off, input logic exp,
                           input string what);
  load_hart_i   = hart_t'(lh);
  page_offset_i = off;
  @(negedge clk_i);
  expect_value(what, 64'(page_offset_matches_o), 64'(exp));
  step();
endtask

// ------------------------------
// drain checking
// ------------------------------
// the next write comes from the first hart at or after the priority pointer
// that still has committed stores, and that hart then goes to the back
task automatic check_drained(input int first);
  int     h;
  int     w;
  int     prio;
  write_t exp;
  prio = first;
  while (log_base < wr_log.size()) begin
    h = -1;
    for (int k = `SP_NUM_HARTS - 1; k >= 0; k--) begin
      if (cmt_model[(prio + k) % `SP_NUM_HARTS].size() > 0) begin
        h = (prio + k) % `SP_NUM_HARTS;
      end
    end
    if (h < 0) begin
      expect_value("APB writes beyond the committed stores", 64'(wr_log.size() - log_base),
                   64'd0);
      log_base = wr_log.size();
    end else begin
      exp = cmt_model[h].pop_front();
      expect_value("APB address", 64'(wr_log[log_base].addr), 64'(exp.addr));
      expect_value("APB write data", 64'(wr_log[log_base].data), 64'(exp.data));
      expect_value("APB strobes", 64'(wr_log[log_base].strb), 64'(exp.strb));
      w         = int'(exp.addr[`SP_ADDR_W-1:2]);
      shadow[w] = merge_bytes(shadow[w], exp.data, exp.strb);
      log_base++;
      prio = (h + 1) % `SP_NUM_HARTS;
    end
  end
  for (int k = 0; k < `SP_NUM_HARTS; k++) begin
    expect_value("committed stores never written", 64'(cmt_model[k].size()), 64'd0);
  end
  compare_memory();
endtask

task automatic compare_memory();
  int bad;
  bad = 0;
  for (int i = 0; i < MEM_WORDS; i++) begin
    if (mem[i] !== shadow[i]) begin
      bad++;
    end
  end
  expect_value("memory words differing from the shadow", 64'(bad), 64'd0);
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic check_reset_state();
  @(negedge clk_i);
  expect_value("psel_o after reset", 64'(psel_o), 64'd0);
  expect_value("penable_o after reset", 64'(penable_o), 64'd0);
  expect_value("ready_o after reset", 64'(ready_o), 64'd1);
  expect_value("commit_ready_o after reset", 64'(commit_ready_o), 64'd1);
  expect_value("store_buffer_empty_o after reset", 64'(store_buffer_empty_o), 64'd1);
  step();
endtask

// stores to a few overlapping words, committed two at a time
task automatic drain_in_order();
  addr_t a;
  for (int k = 0; k < 8; k++) begin
    a = 16'h1000 + addr_t'((k % 3) * 4);
    push_store(0, a, data_t'(32'h1357_9BDF * (k + 1)), strb_t'((k * 5 + 3) % 16));
    if (k % 2 == 1) begin
      commit_store(0);
      commit_store(0);
    end
  end
  wait_empty();
  check_drained(0);
endtask

task automatic flush_drops_stores();
  int hits;
  push_store(1, 16'h2000, 32'hA000_0001, 4'hF);
  commit_store(1);
  push_store(1, 16'h2104, 32'hB000_0002, 4'hF);
  push_store(1, 16'h2108, 32'hC000_0003, 4'h3);
  flush_hart(1);
  push_store(1, 16'h200C, 32'hD000_0004, 4'hC);
  commit_store(1);
  wait_empty();
  hits = 0;
  for (int i = log_base; i < wr_log.size(); i++) begin
    if (wr_log[i].addr == 16'h2104 || wr_log[i].addr == 16'h2108) begin
      hits++;
    end
  end
  expect_value("APB writes to flushed addresses", 64'(hits), 64'd0);
  check_drained(1);
endtask

// both harts fill up behind a stalled port, hart 0 got there first
task automatic alternate_harts();
  set_stall(1'b1);
  for (int k = 0; k < 3; k++) begin
    push_store(0, 16'h6000 + addr_t'(4 * k), data_t'(32'h6060_0000 + k), 4'hF);
    commit_store(0);
  end
  for (int k = 0; k < 3; k++) begin
    push_store(1, 16'h7000 + addr_t'(4 * k), data_t'(32'h7070_0000 + k), 4'hF);
    commit_store(1);
  end
  set_stall(1'b0);
  wait_empty();
  check_drained(0);
endtask

task automatic fill_queues();
  set_stall(1'b1);
  for (int k = 0; k < `SP_DEPTH_SPEC; k++) begin
    push_store(0, 16'h4000 + addr_t'(4 * k), data_t'(32'h4444_0000 + k), 4'hF);
  end
  hart_i = '0;
  @(negedge clk_i);
  expect_value("ready_o with a full speculative queue", 64'(ready_o), 64'd0);
  step();
  // the stalled write keeps the head of the commit queue occupied
  for (int k = 0; k < `SP_DEPTH_COMMIT; k++) begin
    if (spec_model[0].size() == 0) begin
      push_store(0, 16'h4100 + addr_t'(4 * k), data_t'(32'h4545_0000 + k), 4'hF);
    end
    commit_store(0);
  end
  @(negedge clk_i);
  expect_value("commit_ready_o with a full commit queue", 64'(commit_ready_o), 64'd0);
  expect_value("ready_o after commits freed slots", 64'(ready_o), 64'd1);
  step();
  set_stall(1'b0);
  for (int k = 0; k < `SP_DEPTH_SPEC && spec_model[0].size() > 0; k++) begin
    commit_store(0);
  end
  wait_empty();
  hart_i = '0;
  @(negedge clk_i);
  expect_value("ready_o after draining", 64'(ready_o), 64'd1);
  expect_value("commit_ready_o after draining", 64'(commit_ready_o), 64'd1);
  step();
  check_drained(0);
endtask

task automatic match_page_offset();
  set_stall(1'b1);
  push_store(0, 16'h3A48, 32'h3A3A_4848, 4'hF);
  probe_match(0, 12'hA4B, 1'b1, "match for a pending store, same word");
  probe_match(1, 12'hA48, 1'b0, "match for the other hart");
  probe_match(0, 12'hA40, 1'b0, "match for a different word");
  commit_store(0);
  probe_match(0, 12'hA48, 1'b1, "match for a committed store");
  set_stall(1'b0);
  wait_empty();
  probe_match(0, 12'hA48, 1'b0, "match after the store drained");
  check_drained(0);
endtask

task automatic track_empty_flag();
  int n;
  push_store(1, 16'h5010, 32'h5151_5151, 4'h5);
  @(negedge clk_i);
  expect_value("store_buffer_empty_o with a speculative store", 64'(store_buffer_empty_o),
               64'd0);
  step();
  commit_store(1);
  n = 0;
  @(negedge clk_i);
  while (!(psel_o && penable_o && pready_i) && n < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    n++;
  end
  if (!(psel_o && penable_o && pready_i)) begin
    report_timeout("the APB write to complete");
  end
  expect_value("pwrite_o during a write", 64'(pwrite_o), 64'd1);
  expect_value("store_buffer_empty_o before the write ends", 64'(store_buffer_empty_o), 64'd0);
  @(negedge clk_i);
  expect_value("store_buffer_empty_o after the last write", 64'(store_buffer_empty_o), 64'd1);
  step();
  check_drained(1);
endtask

`endif

/* verif/store_path_tb.sv */
/*
 * testbench of the multi-hart store path
 * holds the clock, reset, an APB completer with a memory array and the error counters
 * the directed tests come from the included tests header and run in sequence
 */

`include "store_path_defines.svh"
`default_nettype none

module store_path_tb import store_path_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 400;
  localparam int MEM_WORDS      = 1 << (`SP_ADDR_W - 2);

  // one APB write as the completer saw it, or as a test expects it
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } write_t;

  logic        clk_i;
  logic        arst_n_i;
  hart_t       hart_i;
  logic        push_i;
  addr_t       addr_i;
  data_t       data_i;
  strb_t       strb_i;
  logic        commit_i;
  logic        flush_i;
  logic        ready_o;
  logic        commit_ready_o;
  hart_t       load_hart_i;
  logic [11:0] page_offset_i;
  logic        page_offset_matches_o;
  logic        store_buffer_empty_o;
  logic        psel_o;
  logic        penable_o;
  logic        pwrite_o;
  addr_t       paddr_o;
  data_t       pwdata_o;
  strb_t       pstrb_o;
  logic        pready_i;

  // completer memory, word addressed, and the copy the tests expect
  data_t  mem [MEM_WORDS];
  data_t  shadow [MEM_WORDS];
  write_t wr_log [$];
  // stores per hart that the core has pushed but not committed, and committed ones
  write_t spec_model [`SP_NUM_HARTS][$];
  write_t cmt_model [`SP_NUM_HARTS][$];
  logic   stall_apb;
  int     seed = 51;
  int     n_checks;
  int     n_errors;
  int     log_base;

  store_path_top store_path_top_inst (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .hart_i                (hart_i),
    .push_i                (push_i),
    .addr_i                (addr_i),
    .data_i                (data_i),
    .strb_i                (strb_i),
    .commit_i              (commit_i),
    .flush_i               (flush_i),
    .ready_o               (ready_o),
    .commit_ready_o        (commit_ready_o),
    .load_hart_i           (load_hart_i),
    .page_offset_i         (page_offset_i),
    .page_offset_matches_o (page_offset_matches_o),
    .store_buffer_empty_o  (store_buffer_empty_o),
    .psel_o                (psel_o),
    .penable_o             (penable_o),
    .pwrite_o              (pwrite_o),
    .paddr_o               (paddr_o),
    .pwdata_o              (pwdata_o),
    .pstrb_o               (pstrb_o),
    .pready_i              (pready_i)
  );

  // ------------------------------
  // helpers shared by the tests
  // ------------------------------
  // every word starts with a value that depends on its whole address
  function automatic data_t fill_word(input int idx);
    return data_t'(idx * 32'h9E37_79B1 + 32'h5A5A_0000);
  endfunction

  // APB write with strobes, only the enabled byte lanes change
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t word;
    word = old_word;
    for (int b = 0; b < `SP_DATA_W / 8; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  task automatic expect_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("timeout at %0t ns, gave up waiting for %s", $time, what);
  endtask

  `include "store_path_tests.svh"

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------
  // APB completer
  // ------------------------------
  // pready changes just after each edge, each write gets 0 to 3 wait states
  // unless a test stalls the port on purpose
  initial begin : apb_ready
    int waits;
    waits    = 0;
    pready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (psel_o && !penable_o) begin
        // the first access cycle uses up one count
        waits = ($random(seed) & 3) + 1;
      end else if (psel_o && waits > 0) begin
        waits--;
      end
      pready_i = psel_o && (waits == 0) && !stall_apb;
    end
  end

  // sampled mid cycle, the values here are the ones the next edge completes
  initial begin : apb_memory
    int     w;
    write_t wr;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk_i);
      if (psel_o && penable_o && pready_i) begin
        w      = int'(paddr_o[`SP_ADDR_W-1:2]);
        mem[w] = merge_bytes(mem[w], pwdata_o, pstrb_o);
        wr     = '{addr: paddr_o, data: pwdata_o, strb: pstrb_o};
        wr_log.push_back(wr);
      end
    end
  end

  initial begin : main
    n_checks      = 0;
    n_errors      = 0;
    log_base      = 0;
    stall_apb     = 1'b0;
    arst_n_i      = 1'b0;
    hart_i        = '0;
    push_i        = 1'b0;
    addr_i        = '0;
    data_i        = '0;
    strb_i        = '0;
    commit_i      = 1'b0;
    flush_i       = 1'b0;
    load_hart_i   = '0;
    page_offset_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = fill_word(i);
    end
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    check_reset_state();
    drain_in_order();
    flush_drops_stores();
    alternate_harts();
    fill_queues();
    match_page_offset();
    track_empty_flag();

    $display("checks run %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
